/* files.f */
design/mldsa_pwm_pkg.sv
design/coef_pair_if.sv
design/mod_add_sub.sv
design/mult_reduction.sv
design/pointwise_mult_pipe.sv
design/job_counter.sv
design/pwm_ctrl_fsm.sv
design/pwm_top.sv
verification/pwm_tb_clkgen.sv
verification/pwm_tb.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= pwm_tb
FILELIST ?= files.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/pwm_tb.sv */
// Directed testbench for the ML-DSA pointwise modular multiplier.
// Each test drives a job through pwm_top, a monitor on the rising edge
// checks every result against a 64-bit reference of (a*b) mod q.
// Inputs change on the falling edge only.
`default_nettype none

module pwm_tb;

    localparam int          LEN_W  = 9;
    localparam logic [22:0] Q      = 23'd8380417;
    localparam logic [63:0] Q64    = 64'd8380417;
    // Corner, full rate, back-pressure, bounds, zeroize and follow-up jobs
    localparam int TOTAL_PAIRS     = 8 + 256 + 64 + 6 + 32 + 16;
    localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * 20 + 400;

    logic             clk;
    logic             reset_n;
    logic             zeroize_i;
    logic             start_i;
    logic [LEN_W-1:0] len_i;
    logic             in_valid_i;
    logic [22:0]      in_a_i;
    logic [22:0]      in_b_i;
    logic             in_ready_o;
    logic             out_ready_i;
    logic             out_valid_o;
    logic [22:0]      out_res_o;
    logic             busy_o;
    logic             done_o;

    // Scoreboard state, written by the monitor only
    logic [22:0] exp_q[$];
    logic [22:0] exp_val;
    logic [22:0] held_res;
    logic        stalled;
    int          results_total;
    int          done_total;

    // Job bookkeeping, written by the test sequence only
    logic [22:0] src_a[$];
    logic [22:0] src_b[$];
    int          job_len;
    int          result_base;
    int          done_base;
    logic [31:0] rng_state;
    string       cur_test;
    int          err_count;
    int          err_base;
    int          tests_run;
    int          tests_passed;

    pwm_tb_clkgen u_clkgen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    pwm_top #(
        .LEN_W (LEN_W)
    ) UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .len_i       (len_i),
        .in_valid_i  (in_valid_i),
        .in_a_i      (in_a_i),
        .in_b_i      (in_b_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_res_o   (out_res_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    // ------------------------------------------------------------------
    // Reference model, random source and checking
    // ------------------------------------------------------------------
    function automatic logic [22:0] ref_mulmod(input logic [22:0] a, input logic [22:0] b);
        logic [63:0] prod;
        logic [63:0] rem;
        prod = {41'd0, a} * {41'd0, b};
        rem  = prod % Q64;
        return rem[22:0];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Uniform-ish coefficient below q
    function automatic logic [22:0] rand_coef();
        logic [31:0] r;
        r = next_rand() % 32'd8380417;
        return r[22:0];
    endfunction

    // True with roughly pct percent probability
    function automatic logic percent(input int pct);
        logic [31:0] r;
        r = next_rand() % 32'd100;
        return r < 32'(pct);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h in %s",
                     name, actual, expected, cur_test);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        err_count++;
    endtask

    // ------------------------------------------------------------------
    // Monitor, samples pre-edge values on every rising edge
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (zeroize_i) begin
            // Everything in flight is dropped
            exp_q.delete();
            stalled = 1'b0;
        end else if (reset_n) begin
            if (stalled) begin
                if (!out_valid_o) begin
                    report_error("out_valid_o dropped while the output was stalled");
                end
                check_value("out_res_o held", 32'(out_res_o), 32'(held_res));
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    report_error("result delivered with no pair outstanding");
                end else begin
                    exp_val = exp_q.pop_front();
                    check_value("out_res_o", 32'(out_res_o), 32'(exp_val));
                end
                if (out_res_o >= Q) begin
                    report_error("result not reduced below q");
                end
                results_total++;
            end
            // Expected value queued in acceptance order
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(ref_mulmod(in_a_i, in_b_i));
            end
            if (done_o) begin
                done_total++;
                check_value("results before done_o", results_total - result_base, job_len);
                check_value("pending results at done_o", exp_q.size(), 0);
            end
            stalled  = out_valid_o && !out_ready_i;
            held_res = out_res_o;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    task automatic fill_random(input int len);
        int i;
        src_a.delete();
        src_b.delete();
        for (i = 0; i < len; i++) begin
            src_a.push_back(rand_coef());
            src_b.push_back(rand_coef());
        end
    endtask

    task automatic fill_corner();
        logic [22:0] vals [5];
        int          i;
        vals[0] = 23'd0;
        vals[1] = 23'd1;
        vals[2] = Q - 23'd1;
        vals[3] = 23'h400000;
        vals[4] = Q - 23'd2;
        src_a.delete();
        src_b.delete();
        // Squares first, then a few mixed pairs
        for (i = 0; i < 8; i++) begin
            src_a.push_back(vals[i % 5]);
            src_b.push_back((i < 5) ? vals[i] : vals[(i + 2) % 5]);
        end
    endtask

    // One job, random valid and ready at the given rates
    task automatic run_job(input int len, input int valid_pct, input int ready_pct,
                           input bit poke_start);
        int idx;
        int gaps;
        bit fire;
        bit finished;
        idx      = 0;
        gaps     = 0;
        finished = 1'b0;
        @(negedge clk);
        job_len     = len;
        result_base = results_total;
        done_base   = done_total;
        start_i     = 1'b1;
        len_i       = 9'(len);
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        @(posedge clk);
        while (!finished) begin
            @(negedge clk);
            start_i = 1'b0;
            if (poke_start && idx == len / 2) begin
                // Second start mid-job, must be ignored
                start_i = 1'b1;
                len_i   = 9'(len + 5);
            end
            in_valid_i = percent(valid_pct);
            if (idx < len) begin
                in_a_i = src_a[idx];
                in_b_i = src_b[idx];
            end
            out_ready_i = percent(ready_pct);
            @(posedge clk);
            fire = in_valid_i && in_ready_o;
            if (idx >= len && in_ready_o) begin
                report_error("in_ready_o high after all pairs of the job were accepted");
            end
            if (valid_pct == 100 && ready_pct == 100 && idx < len && !fire) begin
                gaps++;
            end
            if (fire) begin
                idx++;
            end
            // busy_o falls on the same edge that raises done_o
            if (done_o) begin
                finished = 1'b1;
                if (busy_o) begin
                    report_error("busy_o still high together with done_o");
                end
            end else if (!busy_o) begin
                report_error("busy_o low before done_o");
            end
        end
        @(negedge clk);
        start_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        check_value("in_stall_cycles", gaps, 0);
        repeat (3) begin
            @(posedge clk);
            check_value("busy_o after done", 32'(busy_o), 32'd0);
            check_value("in_ready_o after done", 32'(in_ready_o), 32'd0);
        end
        check_value("done_o pulses", done_total - done_base, 1);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic bounds_test();
        // Idle, valid alone never opens the input
        @(negedge clk);
        in_valid_i = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_value("in_ready_o idle", 32'(in_ready_o), 32'd0);
        end
        // Zero length start is dropped
        @(negedge clk);
        start_i = 1'b1;
        len_i   = '0;
        @(negedge clk);
        start_i = 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_value("busy_o after zero length", 32'(busy_o), 32'd0);
            check_value("in_ready_o after zero length", 32'(in_ready_o), 32'd0);
        end
        fill_random(6);
        run_job(6, 100, 30, 1'b1);
    endtask

    task automatic zeroize_test();
        int i;
        fill_random(32);
        @(negedge clk);
        job_len = 32;
        start_i = 1'b1;
        len_i   = 9'd32;
        @(negedge clk);
        start_i = 1'b0;
        // Part of a job, some results still in the pipe
        for (i = 0; i < 20; i++) begin
            in_valid_i  = 1'b1;
            in_a_i      = src_a[i];
            in_b_i      = src_b[i];
            out_ready_i = percent(60);
            @(negedge clk);
        end
        zeroize_i  = 1'b1;
        in_valid_i = 1'b0;
        @(negedge clk);
        zeroize_i = 1'b0;
        repeat (2) begin
            check_value("busy_o after zeroize", 32'(busy_o), 32'd0);
            check_value("in_ready_o after zeroize", 32'(in_ready_o), 32'd0);
            check_value("out_valid_o after zeroize", 32'(out_valid_o), 32'd0);
            @(negedge clk);
        end
        fill_random(16);
        run_job(16, 100, 100, 1'b0);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = err_count;
    endtask

    task automatic end_test();
        int errs;
        errs = err_count - err_base;
        tests_run++;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: PASS", cur_test);
        end else begin
            $display("test %s: FAIL with %0d errors", cur_test, errs);
        end
    endtask

    // Hang guard sized from the summed job lengths
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, test %s did not finish", WATCHDOG_CYCLES, cur_test);
        $display("tests failed");
        $finish;
    end

    initial begin
        zeroize_i     = 1'b0;
        start_i       = 1'b0;
        len_i         = '0;
        in_valid_i    = 1'b0;
        in_a_i        = '0;
        in_b_i        = '0;
        out_ready_i   = 1'b0;
        stalled       = 1'b0;
        held_res      = '0;
        results_total = 0;
        done_total    = 0;
        job_len       = 0;
        result_base   = 0;
        done_base     = 0;
        err_count     = 0;
        err_base      = 0;
        tests_run     = 0;
        tests_passed  = 0;
        rng_state     = 32'h68dc_642c;
        cur_test      = "reset";
        wait (reset_n === 1'b1);

        begin_test("corner_values");
        fill_corner();
        run_job(8, 100, 100, 1'b0);
        end_test();

        begin_test("full_rate");
        fill_random(256);
        run_job(256, 100, 100, 1'b0);
        end_test();

        begin_test("back_pressure");
        fill_random(64);
        run_job(64, 60, 40, 1'b0);
        end_test();

        begin_test("job_bounds");
        bounds_test();
        end_test();

        begin_test("zeroize");
        zeroize_test();
        end_test();

        $display("Summary: %0d tests run, %0d passed, %0d errors",
                 tests_run, tests_passed, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/pwm_tb_clkgen.sv */
// Clock and reset source for the pointwise multiplier testbench.
// Free-running clock of period 100, reset_n_o held low for 16 cycles.
`default_nettype none

module pwm_tb_clkgen (
    output logic clk_o,
    output logic reset_n_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, clear of the DUT's sampling edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* design/pwm_top.sv */
// Top level of the pointwise multiplier, start a job of len_i pairs, stream
// (a, b) in and a*b mod q out, done_o pulses after the last result.
`default_nettype none

module pwm_top #(
    parameter int LEN_W = mldsa_pwm_pkg::LEN_W
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize_i,
    input  logic                              start_i,
    input  logic [LEN_W-1:0]                  len_i,
    input  logic                              in_valid_i,
    input  logic [mldsa_pwm_pkg::COEF_W-1:0] in_a_i,
    input  logic [mldsa_pwm_pkg::COEF_W-1:0] in_b_i,
    output logic                              in_ready_o,
    input  logic                              out_ready_i,
    output logic                              out_valid_o,
    output logic [mldsa_pwm_pkg::COEF_W-1:0] out_res_o,
    output logic                              busy_o,
    output logic                              done_o
);

    logic load;
    logic accept_en;
    logic in_left;
    logic in_last;
    logic out_last;
    logic in_fire;
    logic out_fire;

    coef_pair_if pair_if ();

    // Source side of the pair stream, masked outside the accept window
    assign pair_if.valid = in_valid_i && accept_en;
    assign pair_if.opa   = in_a_i;
    assign pair_if.opb   = in_b_i;
    assign in_ready_o    = pair_if.ready && accept_en;

    // Transfers on both streams
    assign in_fire  = in_valid_i && in_ready_o;
    assign out_fire = out_valid_o && out_ready_i;

    pwm_ctrl_fsm u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .start_i       (start_i),
        .len_nonzero_i (|len_i),
        .in_left_i     (in_left),
        .in_fire_i     (in_fire),
        .in_last_i     (in_last),
        .out_fire_i    (out_fire),
        .out_last_i    (out_last),
        .load_o        (load),
        .accept_en_o   (accept_en),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    job_counter #(
        .LEN_W (LEN_W)
    ) u_cnt (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .load_i     (load),
        .in_fire_i  (in_fire),
        .out_fire_i (out_fire),
        .len_i      (len_i),
        .in_left_o  (in_left),
        .in_last_o  (in_last),
        .out_last_o (out_last)
    );

    pointwise_mult_pipe u_pipe (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .in          (pair_if.snk),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_res_o   (out_res_o)
    );

endmodule

`default_nettype wire

/* design/pwm_ctrl_fsm.sv */
// Job controller FSM, IDLE to RUN on start, DRAIN once all pairs are in.
// Gates input acceptance and produces busy and the done pulse.
`default_nettype none

module pwm_ctrl_fsm (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  logic start_i,
    input  logic len_nonzero_i,
    input  logic in_left_i,
    input  logic in_fire_i,
    input  logic in_last_i,
    input  logic out_fire_i,
    input  logic out_last_i,
    output logic load_o,
    output logic accept_en_o,
    output logic busy_o,
    output logic done_o
);
    import mldsa_pwm_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        job_end;

    // Final result leaves the pipe
    assign job_end = (state_q != IDLE) && out_fire_i && out_last_i;

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        load_o  = 1'b0;
        case (state_q)
            IDLE: begin
                // Zero length never starts a job
                if (start_i && len_nonzero_i) begin
                    load_o  = 1'b1;
                    state_d = RUN;
                end
            end
            RUN: begin
                if (job_end) begin
                    state_d = IDLE;
                end else if (in_fire_i && in_last_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (job_end) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            done_o  <= 1'b0;
        end else if (zeroize_i) begin
            state_q <= IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= job_end;
        end
    end

    // Busy falls on the same edge that raises done
    assign busy_o      = (state_q != IDLE);
    assign accept_en_o = (state_q == RUN) && in_left_i;

    // Done is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o
    );

endmodule

`default_nettype wire

/* design/job_counter.sv */
// Pair and result counters for one job.
// Both load with the job length and count down on their own transfers.
`default_nettype none

module job_counter #(
    parameter int LEN_W = mldsa_pwm_pkg::LEN_W
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize_i,
    input  logic             load_i,
    input  logic             in_fire_i,
    input  logic             out_fire_i,
    input  logic [LEN_W-1:0] len_i,
    output logic             in_left_o,
    output logic             in_last_o,
    output logic             out_last_o
);

    // Pairs still to accept, results still to deliver
    logic [LEN_W-1:0] in_cnt_q;
    logic [LEN_W-1:0] out_cnt_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_cnt_q  <= '0;
            out_cnt_q <= '0;
        end else if (zeroize_i) begin
            in_cnt_q  <= '0;
            out_cnt_q <= '0;
        end else if (load_i) begin
            in_cnt_q  <= len_i;
            out_cnt_q <= len_i;
        end else begin
            if (in_fire_i) begin
                in_cnt_q <= in_cnt_q - LEN_W'(1);
            end
            if (out_fire_i) begin
                out_cnt_q <= out_cnt_q - LEN_W'(1);
            end
        end
    end

    assign in_left_o  = (in_cnt_q != '0);
    // Last flags mark the final transfer of each kind
    assign in_last_o  = (in_cnt_q == LEN_W'(1));
    assign out_last_o = (out_cnt_q == LEN_W'(1));

    // Controller never lets a pair through past the job length
    a_in_no_underflow: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        in_fire_i |-> (in_cnt_q != '0)
    );

    // Nor a result past the job length
    a_out_no_underflow: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        out_fire_i |-> (out_cnt_q != '0)
    );

endmodule

`default_nettype wire

/* design/pointwise_mult_pipe.sv */
// Multiply pipeline, a*b product register followed by the mod q reduction.
// A single advance signal moves every stage, so back-pressure on the output
// freezes the whole pipe without losing data.
`default_nettype none

module pointwise_mult_pipe (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize_i,
    coef_pair_if.snk                          in,
    input  logic                              out_ready_i,
    output logic                              out_valid_o,
    output logic [mldsa_pwm_pkg::COEF_W-1:0] out_res_o
);
    import mldsa_pwm_pkg::*;

    logic                advance;
    logic                in_fire;
    logic [2*COEF_W-1:0] prod_q;
    // One bit per stage, oldest at the top
    logic [PIPE_LAT-1:0] vld_q;

    // ------------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------------

    // Move when the output slot is free or being drained
    assign advance     = !out_valid_o || out_ready_i;
    assign in.ready    = advance;
    assign in_fire     = in.valid && advance;
    assign out_valid_o = vld_q[PIPE_LAT-1];

    // Valid tracking, shifts in lock step with the data stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= '0;
        end else if (zeroize_i) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q <= {vld_q[PIPE_LAT-2:0], in_fire};
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------

    // Full 46-bit product, loaded only on an accepted pair
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else if (in_fire) begin
            prod_q <= {{COEF_W{1'b0}}, in.opa} * {{COEF_W{1'b0}}, in.opb};
        end
    end

    // Four more stages to the residue
    mult_reduction u_red (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (advance),
        .prod_i    (prod_q),
        .res_o     (out_res_o)
    );

    // Stalled result holds its value
    a_out_stable: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        (out_valid_o && !out_ready_i) |=> $stable(out_res_o)
    );

    // Valid only drops after a transfer
    a_out_valid_held: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        (out_valid_o && !out_ready_i) |=> out_valid_o
    );

endmodule

`default_nettype wire

/* design/mult_reduction.sv */
// Reduction of a 46-bit product modulo q, specific to the ML-DSA prime.
// Uses 2^23 = 2^13 - 1 (mod q) to fold the product into two partial sums,
// reduces each with a modular adder and subtracts them.
// Four stages, every one advances only when en_i is high.
`default_nettype none

module mult_reduction (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic                                en_i,
    input  logic [2*mldsa_pwm_pkg::COEF_W-1:0] prod_i,
    output logic [mldsa_pwm_pkg::COEF_W-1:0]   res_o
);
    import mldsa_pwm_pkg::*;

    // Stage 1 product flop
    logic [2*COEF_W-1:0] z_q;

    // Fold terms
    logic [11:0]         c;
    logic [10:0]         d;
    logic [13:0]         f;
    logic [COEF_W:0]     g;

    // Stage 2 and 3 results
    logic [COEF_W-1:0]   e_q;
    logic [COEF_W:0]     g_red_q;
    logic [COEF_W-1:0]   diff_q;

    // ------------------------------------------------------------------
    // Stage 1, flop the product
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            z_q <= '0;
        end else if (zeroize_i) begin
            z_q <= '0;
        end else if (en_i) begin
            z_q <= prod_i;
        end
    end

    // ------------------------------------------------------------------
    // Fold the product
    // ------------------------------------------------------------------
    // Fields [45:43] [42:33] [32:23] [22:13] [12:0]
    // z = E + 2^13*c - (z[45:23] + z[45:33] + z[45:43])
    always_comb begin
        // Sum of the 2^13-weighted fields, at most 12 bits
        c = {9'd0, z_q[45:43]} + {2'd0, z_q[42:33]}
          + {2'd0, z_q[32:23]} + {2'd0, z_q[22:13]};
        // Fold bits 11:10 of c again, 2^10 * 2^13 = 2^23
        d = {9'd0, c[11:10]} + {1'b0, c[9:0]};
        // Negative-side small terms, including the fold remainder
        f = {11'd0, z_q[45:43]} + {1'b0, z_q[45:33]} + {12'd0, c[11:10]};
        // Positive-side high part, below 2q
        g = {d, 13'd0};
    end

    // ------------------------------------------------------------------
    // Stage 2, two parallel modular adds
    // ------------------------------------------------------------------

    // Negative side, f + z[45:23] mod q
    mod_add_sub #(
        .REG_SIZE (COEF_W)
    ) u_add_neg (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (en_i),
        .sub_i     (1'b0),
        .opa_i     ({9'd0, f}),
        .opb_i     (z_q[45:23]),
        .prime_i   (MLDSA_Q),
        .res_o     (e_q)
    );

    // Positive side, g + z[12:0] mod q, one bit wider since g may exceed q
    mod_add_sub #(
        .REG_SIZE (COEF_W + 1)
    ) u_add_pos (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (en_i),
        .sub_i     (1'b0),
        .opa_i     (g),
        .opb_i     ({11'd0, z_q[12:0]}),
        .prime_i   ({1'b0, MLDSA_Q}),
        .res_o     (g_red_q)
    );

    // ------------------------------------------------------------------
    // Stage 3, positive minus negative mod q
    // ------------------------------------------------------------------
    mod_add_sub #(
        .REG_SIZE (COEF_W)
    ) u_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (en_i),
        .sub_i     (1'b1),
        .opa_i     (g_red_q[COEF_W-1:0]),
        .opb_i     (e_q),
        .prime_i   (MLDSA_Q),
        .res_o     (diff_q)
    );

    // Stage 4 output flop
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else if (en_i) begin
            res_o <= diff_q;
        end
    end

    // Wide adder result always fits a coefficient
    a_pos_fits: assert property (
        @(posedge clk) disable iff (!reset_n)
        g_red_q[COEF_W] == 1'b0
    );

endmodule

`default_nettype wire

/* design/mod_add_sub.sv */
// Registered modular adder/subtractor with one result per enabled cycle.
// Operands below prime_i give a result below prime_i on the next edge.
// sub_i selects opa_i - opb_i, otherwise opa_i + opb_i.
`default_nettype none

module mod_add_sub #(
    parameter int REG_SIZE = 23
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                en_i,
    input  logic                sub_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    input  logic [REG_SIZE-1:0] prime_i,
    output logic [REG_SIZE-1:0] res_o
);

    // One extra bit for carry or borrow
    logic [REG_SIZE:0]   raw;
    logic [REG_SIZE:0]   corr;
    logic [REG_SIZE-1:0] res_d;

    // ------------------------------------------------------------------
    // Sum or difference with single correction by the prime
    // ------------------------------------------------------------------
    always_comb begin
        if (sub_i) begin
            raw  = {1'b0, opa_i} - {1'b0, opb_i};
            // Borrow set means negative, add the prime back
            corr = raw + {1'b0, prime_i};
            res_d = raw[REG_SIZE] ? corr[REG_SIZE-1:0] : raw[REG_SIZE-1:0];
        end else begin
            raw  = {1'b0, opa_i} + {1'b0, opb_i};
            // Top bit set here means sum was below the prime
            corr = raw - {1'b0, prime_i};
            res_d = corr[REG_SIZE] ? raw[REG_SIZE-1:0] : corr[REG_SIZE-1:0];
        end
    end

    // Result register, holds while disabled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else if (zeroize_i) begin
            res_o <= '0;
        end else if (en_i) begin
            res_o <= res_d;
        end
    end

    // Reduced operands stay reduced through the unit
    a_res_below_prime: assert property (
        @(posedge clk) disable iff (!reset_n)
        (en_i && (opa_i < prime_i) && (opb_i < prime_i)) |=> (res_o < $past(prime_i))
    );

endmodule

`default_nettype wire

/* design/coef_pair_if.sv */
// Valid/ready stream of (a, b) coefficient pairs into the multiply pipeline.
// The top level drives the source side, the pipeline drives ready.
`default_nettype none

interface coef_pair_if;
    import mldsa_pwm_pkg::*;

    // Handshake
    logic              valid;
    logic              ready;

    // Operand payload
    logic [COEF_W-1:0] opa;
    logic [COEF_W-1:0] opb;

    // Producer side
    modport src (
        output valid,
        output opa,
        output opb,
        input  ready
    );

    // Consumer side, transfer when valid and ready
    modport snk (
        input  valid,
        input  opa,
        input  opb,
        output ready
    );

endinterface

`default_nettype wire

/* design/mldsa_pwm_pkg.sv */
// Shared constants and types for the ML-DSA pointwise modular multiplier.
// Import into a module body with a wildcard, or use scoped names in headers.
`default_nettype none

package mldsa_pwm_pkg;

    // ------------------------------------------------------------------
    // Arithmetic constants
    // ------------------------------------------------------------------

    // Coefficient width, every residue fits in 23 bits
    localparam int COEF_W = 23;

    // ML-DSA modulus, q = 2^23 - 2^13 + 1
    localparam logic [COEF_W-1:0] MLDSA_Q = 23'd8380417;

    // ------------------------------------------------------------------
    // Job and pipeline sizing
    // ------------------------------------------------------------------

    // Job length width, holds 1 to 256
    localparam int LEN_W = 9;

    // Input accept to output valid without stall
    // Product register plus four reduction stages
    localparam int PIPE_LAT = 5;

    // Job controller states
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        RUN   = 2'b01,
        DRAIN = 2'b10
    } ctrl_state_t;

endpackage

`default_nettype wire
